//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32i_isa_pkg.sv
      - logic/ooo_core_pkg.sv
      - logic/ooo_core_if.sv
      - logic/decode_rename.sv
      - logic/exec_slot.sv
      - logic/cdb_arbiter.sv
      - logic/reorder_buffer.sv
      - logic/ooo_core_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_ooo_core.sv

//--- build.f
+incdir+logic
logic/rv32i_isa_pkg.sv
logic/ooo_core_pkg.sv
logic/ooo_core_if.sv
logic/decode_rename.sv
logic/exec_slot.sv
logic/cdb_arbiter.sv
logic/reorder_buffer.sv
logic/ooo_core_top.sv
tb/tb_ooo_core.sv

//--- logic/cdb_arbiter.sv
`include "core_params.svh"

module cdb_arbiter
    import ooo_core_pkg::*;
(
    input  logic [`NUM_SLOTS-1:0] req_i,
    input  rob_tag_t              tag_i    [`NUM_SLOTS],
    input  logic [`XLEN-1:0]      result_i [`NUM_SLOTS],
    output logic [`NUM_SLOTS-1:0] grant_o,
    cdb_if.drive                  cdb
);

    logic found;

    // fixed priority, slot 0 first
    always_comb begin
        found     = 1'b0;
        grant_o   = '0;
        cdb.valid = 1'b0;
        cdb.tag   = '0;
        cdb.value = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (req_i[i] && !found) begin
                found      = 1'b1;
                grant_o[i] = 1'b1;
                cdb.valid  = 1'b1;
                cdb.tag    = tag_i[i];
                cdb.value  = result_i[i];
            end
        end
    end

endmodule

//--- logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width
`define XLEN 32

// x0 to x31
`define NUM_ARCH_REGS 32

// power of two, so the ROB pointers wrap on their own
`define ROB_DEPTH 8

// identical integer ALU reservation slots
`define NUM_SLOTS 3

`endif

//--- logic/decode_rename.sv
`include "core_params.svh"

module decode_rename
    import rv32i_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid_i,
    input  logic [`XLEN-1:0]   inst_i,
    output logic               ready_o,
    issue_if.dispatch          issue [`NUM_SLOTS],
    cdb_if.listen              cdb,
    rob_lookup_if.rename       rob
);

    decoded_inst_t                 dec;
    issue_packet_t                 packet;
    logic                          load;
    logic [`NUM_SLOTS-1:0]         slot_busy;
    logic [$clog2(`NUM_SLOTS)-1:0] slot_sel;
    logic                          slot_found;

    // register alias table next to the architectural file
    logic [`XLEN-1:0]              arf [`NUM_ARCH_REGS];
    logic [`NUM_ARCH_REGS-1:0]     renamed;
    rob_tag_t                      alias_tag [`NUM_ARCH_REGS];

    // alt picks sub or sra
    function automatic alu_op_e alu_op_of(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // arf value, else ROB value, else same-cycle bus value, else wait on the tag
    function automatic operand_t read_src(logic use_src, logic [4:0] r,
                                          logic rob_done, logic [`XLEN-1:0] rob_value);
        operand_t src;
        src.ready = 1'b1;
        src.tag   = alias_tag[r];
        src.value = arf[r];
        if (!use_src) begin
            src.value = '0;
        end else if (renamed[r]) begin
            if (rob_done) begin
                src.value = rob_value;
            end else if (cdb.valid && cdb.tag == alias_tag[r]) begin
                src.value = cdb.value;
            end else begin
                src.ready = 1'b0;
            end
        end
        return src;
    endfunction

    // unsupported opcodes fall through as add x0, x0, 0
    always_comb begin
        dec         = '0;
        dec.op      = alu_add;
        dec.imm_sel = 1'b1;
        case (inst_i[6:0])
            op_lui: begin
                dec.rd  = inst_i[11:7];
                dec.imm = {inst_i[31:12], 12'b0};
            end
            op_imm: begin
                dec.op      = alu_op_of(inst_i[14:12], inst_i[30] && inst_i[14:12] == 3'b101);
                dec.rd      = inst_i[11:7];
                dec.rs1     = inst_i[19:15];
                dec.use_rs1 = 1'b1;
                dec.imm     = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            op_reg: begin
                dec.op      = alu_op_of(inst_i[14:12], inst_i[30]);
                dec.rd      = inst_i[11:7];
                dec.rs1     = inst_i[19:15];
                dec.rs2     = inst_i[24:20];
                dec.use_rs1 = 1'b1;
                dec.use_rs2 = 1'b1;
                dec.imm_sel = 1'b0;
            end
            default: begin
            end
        endcase
    end

    assign rob.src1_tag = alias_tag[dec.rs1];
    assign rob.src2_tag = alias_tag[dec.rs2];

    always_comb begin
        packet.op   = dec.op;
        packet.dest = rob.tail_tag;
        packet.src1 = read_src(dec.use_rs1, dec.rs1, rob.src1_done, rob.src1_value);
        packet.src2 = read_src(dec.use_rs2, dec.rs2, rob.src2_done, rob.src2_value);
        if (dec.imm_sel) begin
            packet.src2.value = dec.imm;
        end
    end

    // lowest idle slot wins
    always_comb begin
        slot_found = 1'b0;
        slot_sel   = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                slot_found = 1'b1;
                slot_sel   = $bits(slot_sel)'(i);
            end
        end
    end

    assign ready_o      = slot_found && !rob.full;
    assign load         = inst_valid_i && ready_o;
    assign rob.alloc    = load;
    assign rob.alloc_rd = dec.rd;

    for (genvar i = 0; i < `NUM_SLOTS; i++) begin : g_issue
        assign slot_busy[i]    = issue[i].busy;
        assign issue[i].valid  = load && slot_sel == i;
        assign issue[i].packet = packet;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                arf[r] <= '0;
            end
            renamed <= '0;
        end else begin
            if (rob.commit_valid && rob.commit_rd != 5'd0) begin
                arf[rob.commit_rd] <= rob.commit_value;
                // only drop the alias if no younger writer took it over
                if (alias_tag[rob.commit_rd] == rob.commit_tag) begin
                    renamed[rob.commit_rd] <= 1'b0;
                end
            end
            // a new writer overrides the clear above
            if (load && dec.rd != 5'd0) begin
                renamed[dec.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && dec.rd != 5'd0) begin
            alias_tag[dec.rd] <= rob.tail_tag;
        end
    end

endmodule

//--- logic/exec_slot.sv
`include "core_params.svh"

module exec_slot
    import rv32i_isa_pkg::*;
    import ooo_core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    issue_if.slot            issue,
    cdb_if.listen            cdb,
    output logic             req_o,
    output rob_tag_t         tag_o,
    output logic [`XLEN-1:0] result_o,
    input  logic             grant_i
);

    slot_state_e state;
    alu_op_e     op;
    operand_t    src1;
    operand_t    src2;

    // pick up a missing operand when its producer broadcasts
    function automatic operand_t snoop(operand_t src, logic bus_valid, rob_tag_t bus_tag,
                                       logic [`XLEN-1:0] bus_value);
        operand_t upd;
        upd = src;
        if (!src.ready && bus_valid && bus_tag == src.tag) begin
            upd.ready = 1'b1;
            upd.value = bus_value;
        end
        return upd;
    endfunction

    // LUI arrives as an add of zero and the immediate
    function automatic logic [`XLEN-1:0] alu(alu_op_e f, logic [`XLEN-1:0] a,
                                             logic [`XLEN-1:0] b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << shamt;
            alu_slt:  return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: return {{(`XLEN-1){1'b0}}, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> shamt;
            alu_sra:  return $signed(a) >>> shamt;
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    assign issue.busy = state != slot_idle;
    assign req_o      = state == slot_wait_bus;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= slot_idle;
        end else begin
            case (state)
                slot_idle: begin
                    if (issue.valid) begin
                        state <= slot_wait_operands;
                    end
                end
                slot_wait_operands: begin
                    if (src1.ready && src2.ready) begin
                        state <= slot_wait_bus;
                    end
                end
                slot_wait_bus: begin
                    // held until the arbiter picks this slot
                    if (grant_i) begin
                        state <= slot_idle;
                    end
                end
                default: state <= slot_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == slot_idle && issue.valid) begin
            op    <= issue.packet.op;
            tag_o <= issue.packet.dest;
            src1  <= issue.packet.src1;
            src2  <= issue.packet.src2;
        end else if (state == slot_wait_operands) begin
            src1 <= snoop(src1, cdb.valid, cdb.tag, cdb.value);
            src2 <= snoop(src2, cdb.valid, cdb.tag, cdb.value);
            if (src1.ready && src2.ready) begin
                result_o <= alu(op, src1.value, src2.value);
            end
        end
    end

endmodule

//--- logic/ooo_core_if.sv
`include "core_params.svh"

// dispatch into one reservation slot
interface issue_if
    import ooo_core_pkg::*;
();
    logic          valid;
    issue_packet_t packet;
    logic          busy;

    modport dispatch (output valid, output packet, input busy);
    modport slot (input valid, input packet, output busy);
endinterface

// common data bus, one broadcast per cycle
interface cdb_if
    import ooo_core_pkg::*;
();
    logic             valid;
    rob_tag_t         tag;
    logic [`XLEN-1:0] value;

    modport drive (output valid, output tag, output value);
    modport listen (input valid, input tag, input value);
endinterface

// rename stage to ROB: allocation, source lookups and commit
interface rob_lookup_if
    import ooo_core_pkg::*;
();
    logic             alloc;
    logic [4:0]       alloc_rd;
    logic             full;
    rob_tag_t         tail_tag;
    rob_tag_t         src1_tag;
    rob_tag_t         src2_tag;
    logic             src1_done;
    logic             src2_done;
    logic [`XLEN-1:0] src1_value;
    logic [`XLEN-1:0] src2_value;
    logic             commit_valid;
    logic [4:0]       commit_rd;
    logic [`XLEN-1:0] commit_value;
    rob_tag_t         commit_tag;

    modport rename (
        output alloc, alloc_rd, src1_tag, src2_tag,
        input  full, tail_tag, src1_done, src2_done, src1_value, src2_value,
        input  commit_valid, commit_rd, commit_value, commit_tag
    );
    modport rob (
        input  alloc, alloc_rd, src1_tag, src2_tag,
        output full, tail_tag, src1_done, src2_done, src1_value, src2_value,
        output commit_valid, commit_rd, commit_value, commit_tag
    );
endinterface

//--- logic/ooo_core_pkg.sv
`include "core_params.svh"

package ooo_core_pkg;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;

    // value is only meaningful once ready is set
    typedef struct packed {
        logic                ready;
        rob_tag_t            tag;
        logic [`XLEN-1:0]    value;
    } operand_t;

    typedef enum logic [1:0] {
        slot_idle,
        slot_wait_operands,
        slot_wait_bus
    } slot_state_e;

    // what a slot needs to run one instruction
    typedef struct packed {
        rv32i_isa_pkg::alu_op_e op;
        rob_tag_t               dest;
        operand_t               src1;
        operand_t               src2;
    } issue_packet_t;

endpackage

//--- logic/ooo_core_top.sv
`include "core_params.svh"

module ooo_core_top
    import ooo_core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid_i,
    input  logic [`XLEN-1:0] inst_i,
    output logic             ready_o,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output logic [`XLEN-1:0] commit_data_o
);

    issue_if      issue [`NUM_SLOTS] ();
    cdb_if        cdb ();
    rob_lookup_if rob_bus ();

    logic [`NUM_SLOTS-1:0] slot_req;
    logic [`NUM_SLOTS-1:0] slot_grant;
    rob_tag_t              slot_tag    [`NUM_SLOTS];
    logic [`XLEN-1:0]      slot_result [`NUM_SLOTS];

    decode_rename u_decode_rename (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .ready_o      (ready_o),
        .issue        (issue),
        .cdb          (cdb),
        .rob          (rob_bus)
    );

    for (genvar i = 0; i < `NUM_SLOTS; i++) begin : g_slot
        exec_slot u_exec_slot (
            .clk      (clk),
            .rst      (rst),
            .issue    (issue[i]),
            .cdb      (cdb),
            .req_o    (slot_req[i]),
            .tag_o    (slot_tag[i]),
            .result_o (slot_result[i]),
            .grant_i  (slot_grant[i])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .req_i    (slot_req),
        .tag_i    (slot_tag),
        .result_i (slot_result),
        .grant_o  (slot_grant),
        .cdb      (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk            (clk),
        .rst            (rst),
        .cdb            (cdb),
        .rob            (rob_bus),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

//--- logic/reorder_buffer.sv
`include "core_params.svh"

module reorder_buffer
    import ooo_core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    cdb_if.listen            cdb,
    rob_lookup_if.rob        rob,
    output logic             commit_valid_o,
    output logic [4:0]       commit_rd_o,
    output logic [`XLEN-1:0] commit_data_o
);

    rob_tag_t                      head;
    rob_tag_t                      tail;
    rob_tag_t                      commit_tag;
    logic [$clog2(`ROB_DEPTH):0]   count;
    logic [`ROB_DEPTH-1:0]         done;
    logic [4:0]                    rd_mem    [`ROB_DEPTH];
    logic [`XLEN-1:0]              value_mem [`ROB_DEPTH];
    logic                          retire;

    // oldest entry leaves once its result is in
    assign retire = count != '0 && done[head];

    assign rob.full       = count == `ROB_DEPTH;
    assign rob.tail_tag   = tail;
    assign rob.src1_done  = done[rob.src1_tag];
    assign rob.src2_done  = done[rob.src2_tag];
    assign rob.src1_value = value_mem[rob.src1_tag];
    assign rob.src2_value = value_mem[rob.src2_tag];

    // the rename stage writes the arch file from the same commit
    assign rob.commit_valid = commit_valid_o;
    assign rob.commit_rd    = commit_rd_o;
    assign rob.commit_value = commit_data_o;
    assign rob.commit_tag   = commit_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            done           <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire;
            if (retire) begin
                head <= head + 1'b1;
            end
            if (rob.alloc) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            // the bus never carries the tag being allocated
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            count <= count + $bits(count)'(rob.alloc) - $bits(count)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rob.alloc) begin
            rd_mem[tail] <= rob.alloc_rd;
        end
        if (cdb.valid) begin
            value_mem[cdb.tag] <= cdb.value;
        end
        if (retire) begin
            commit_rd_o   <= rd_mem[head];
            commit_data_o <= value_mem[head];
            commit_tag    <= head;
        end
    end

endmodule

//--- logic/rv32i_isa_pkg.sv
`include "core_params.svh"

package rv32i_isa_pkg;

    // the only major opcodes the core executes
    typedef enum logic [6:0] {
        op_lui = 7'b0110111,
        op_imm = 7'b0010011,
        op_reg = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // imm_sel replaces rs2 by the immediate
    typedef struct packed {
        alu_op_e             op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                use_rs1;
        logic                use_rs2;
        logic                imm_sel;
        logic [`XLEN-1:0]    imm;
    } decoded_inst_t;

endpackage

//--- tb/tb_ooo_core.sv
`include "core_params.svh"

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACCEPT_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT   = 1000;
    localparam int MODE_INDEP      = 0;
    localparam int MODE_CHAIN      = 1;
    localparam int MODE_ZERO_SHIFT = 2;
    localparam int MODE_TIGHT      = 3;

    logic             clk;
    logic             rst;
    logic             inst_valid_i;
    logic [`XLEN-1:0] inst_i;
    logic             ready_o;
    logic             commit_valid_o;
    logic [4:0]       commit_rd_o;
    logic [`XLEN-1:0] commit_data_o;

    integer           seed;
    string            test_name;
    logic [`XLEN-1:0] model_regs [`NUM_ARCH_REGS];
    logic [4:0]       exp_rd_q [$];
    logic [`XLEN-1:0] exp_data_q [$];
    string            exp_name_q [$];
    logic [4:0]       recent_rd [3];
    int               accepted;
    int               committed;
    int               stall_cycles;

    ooo_core_top dut (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .ready_o        (ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERR %s %s expected 0x%08h actual 0x%08h", name, field, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // RV32I integer semantics, funct3 selects the operation
    function automatic logic [31:0] ref_alu(logic [2:0] funct3, logic alt,
                                            logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (funct3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // in-order model, one instruction at a time
    task automatic model_step(input logic [31:0] inst, output logic [4:0] rd,
                              output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        rd = inst[11:7];
        a  = model_regs[inst[19:15]];
        case (inst[6:0])
            7'b0110111: value = {inst[31:12], 12'h000};
            7'b0010011: begin
                b     = {{20{inst[31]}}, inst[31:20]};
                value = ref_alu(inst[14:12], inst[14:12] == 3'b101 && inst[30], a, b);
            end
            7'b0110011: begin
                b     = model_regs[inst[24:20]];
                value = ref_alu(inst[14:12], inst[30], a, b);
            end
            default: begin
                rd    = 5'd0;
                value = '0;
            end
        endcase
        // x0 stays zero
        if (rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endtask

    function automatic logic [4:0] pick_src(int mode);
        if (mode == MODE_INDEP) begin
            return 5'(rand_below(32));
        end
        if (mode == MODE_ZERO_SHIFT && rand_below(3) == 0) begin
            return 5'd0;
        end
        return recent_rd[rand_below(3)];
    endfunction

    task automatic build_inst(input int mode, output logic [31:0] inst);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        alt;
        logic [6:0]  funct7;
        logic [11:0] imm;
        logic [19:0] upper;
        int          kind;
        rd     = 5'(1 + rand_below(31));
        rs1    = pick_src(mode);
        rs2    = pick_src(mode);
        funct3 = 3'(rand_below(8));
        alt    = rand_below(2) == 1;
        imm    = 12'($random(seed));
        upper  = 20'($random(seed));
        kind   = rand_below(8);
        if (mode == MODE_INDEP) begin
            rd = 5'(rand_below(32));
        end else if (mode == MODE_ZERO_SHIFT) begin
            if (rand_below(4) == 0) begin
                rd = 5'd0;
            end
            // mostly shifts here
            if (rand_below(4) != 0) begin
                funct3 = (rand_below(2) == 0) ? 3'b001 : 3'b101;
            end
        end else if (mode == MODE_TIGHT) begin
            rs1 = recent_rd[0];
        end
        funct7 = ((funct3 == 3'b000 || funct3 == 3'b101) && alt) ? 7'b0100000 : 7'b0;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
            imm = {(funct3 == 3'b101) ? funct7 : 7'b0, imm[4:0]};
        end
        if (kind == 0) begin
            inst = {upper, rd, 7'b0110111};
        end else if (kind <= 3) begin
            inst = {imm, rs1, funct3, rd, 7'b0010011};
        end else if (kind == 7 && mode == MODE_INDEP) begin
            // load opcode, not supported by the core
            inst = {upper, rd, 7'b0000011};
        end else begin
            inst = {funct7, rs2, rs1, funct3, rd, 7'b0110011};
        end
        recent_rd[2] = recent_rd[1];
        recent_rd[1] = recent_rd[0];
        recent_rd[0] = rd;
    endtask

    // returns on the edge that accepts the instruction
    task automatic send_inst(input logic [31:0] inst);
        int waited;
        waited = 0;
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        @(posedge clk);
        while (!ready_o) begin
            stall_cycles++;
            waited++;
            assert (waited < ACCEPT_TIMEOUT)
                else fail_run("timeout: ready_o stayed low, instruction not accepted");
            @(posedge clk);
        end
    endtask

    task automatic run_phase(input string name, input int mode, input int count,
                             input bit gaps);
        logic [31:0] inst;
        int          gap;
        test_name <= name;
        for (int n = 0; n < count; n++) begin
            build_inst(mode, inst);
            send_inst(inst);
            if (gaps) begin
                gap = rand_below(3);
                if (gap != 0) begin
                    inst_valid_i <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end
        end
    endtask

    always @(posedge clk) begin : monitor
        logic [4:0]  m_rd;
        logic [31:0] m_data;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        string       exp_name;
        if (!rst) begin
            if (inst_valid_i && ready_o) begin
                model_step(inst_i, m_rd, m_data);
                exp_rd_q.push_back(m_rd);
                exp_data_q.push_back(m_data);
                exp_name_q.push_back(test_name);
                accepted++;
            end
            if (commit_valid_o) begin
                assert (exp_rd_q.size() > 0)
                    else fail_run("a commit arrived with no instruction outstanding");
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                exp_name = exp_name_q.pop_front();
                assert (commit_rd_o == exp_rd)
                    else report_mismatch(exp_name, "commit_rd_o", exp_rd, commit_rd_o);
                assert (commit_data_o == exp_data)
                    else report_mismatch(exp_name, "commit_data_o", exp_data, commit_data_o);
                committed++;
            end
            assert (accepted - committed <= `ROB_DEPTH)
                else fail_run($sformatf("%0d instructions in flight, more than the ROB holds",
                                        accepted - committed));
        end
    end

    initial begin
        int waited;
        seed         = 32'h40e92f6e;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        test_name    = "reset_state";
        accepted     = 0;
        committed    = 0;
        stall_cycles = 0;
        recent_rd    = '{5'd1, 5'd2, 5'd3};
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // idle outputs right after reset
        for (int n = 0; n < 4; n++) begin
            @(posedge clk);
            assert (ready_o === 1'b1)
                else report_mismatch("reset_state", "ready_o", 1, ready_o);
            assert (commit_valid_o === 1'b0)
                else report_mismatch("reset_state", "commit_valid_o", 0, commit_valid_o);
        end

        run_phase("random_independent", MODE_INDEP, 80, 1'b1);
        run_phase("dependence_chains", MODE_CHAIN, 80, 1'b1);
        run_phase("x0_and_shifts", MODE_ZERO_SHIFT, 80, 1'b1);
        stall_cycles = 0;
        run_phase("back_pressure", MODE_TIGHT, 60, 1'b0);
        assert (stall_cycles > 0)
            else fail_run("ready_o never dropped while inst_valid_i was held high");

        inst_valid_i <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (exp_rd_q.size() != 0) begin
            waited++;
            assert (waited < DRAIN_TIMEOUT)
                else fail_run("timeout: outstanding instructions did not all commit");
            @(negedge clk);
        end
        // any stray commit here is caught by the monitor
        repeat (8) @(negedge clk);
        // slots free and ROB no longer full once everything retired
        assert (ready_o === 1'b1)
            else report_mismatch("drain", "ready_o", 1, ready_o);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
